//--- include/bus_macros.svh
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// Data word carried on the serial bus
`define BUS_DATA_W 8

// Full address is slave id followed by offset
`define BUS_ADDR_W 15
`define BUS_SLV_ID_W 3
`define BUS_OFFSET_W 12

// Masters sharing the bus
`define BUS_NUM_MASTERS 2

// Low offset bits that index slave memory (16 words)
`define BUS_MEM_ADDR_W 4

`endif

//--- hw/bus_pkg.sv
`default_nettype none

`include "bus_macros.svh"

package bus_pkg;

    // Address fields as seen by the slave decoder
    typedef struct packed {
        logic [`BUS_SLV_ID_W-1:0] slv_id;
        logic [`BUS_OFFSET_W-1:0] offset;
    } bus_addr_fields_t;

    // Flat view is shifted out by the master, field view is decoded by the slave
    typedef union packed {
        logic [`BUS_ADDR_W-1:0] flat;
        bus_addr_fields_t       fields;
    } bus_addr_u;

    typedef struct packed {
        logic                   execute; // One-cycle strobe
        logic                   rw;      // 1 = write
        bus_addr_u              addr;
        logic [`BUS_DATA_W-1:0] wdata;
    } master_cmd_t;

    typedef struct packed {
        logic                   dvalid;
        logic                   error;   // No slave answered
        logic [`BUS_DATA_W-1:0] rdata;
    } master_rsp_t;

    typedef struct packed {
        logic sdata;
        logic rw;
        logic active;
    } bus_lines_t;

endpackage

`default_nettype wire

//--- hw/bus_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module bus_master (
    input  logic                 clk,
    input  logic                 arst_n,
    input  bus_pkg::master_cmd_t cmd,
    input  logic                 grant,
    input  logic                 ret,
    output logic                 request,
    output bus_pkg::bus_lines_t  lines,
    output bus_pkg::master_rsp_t rsp,
    output logic                 busy
);
    import bus_pkg::*;

    localparam int CNT_W = $clog2(`BUS_ADDR_W);
    localparam logic [CNT_W-1:0] ADDR_LAST = CNT_W'(`BUS_ADDR_W - 1);
    localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(`BUS_DATA_W - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_GNT,
        ST_ADDR,
        ST_ACK,
        ST_WDATA,
        ST_RDATA,
        ST_DONE
    } state_t;

    state_t                 state_q;
    logic [CNT_W-1:0]       bit_cnt_q;
    logic [`BUS_ADDR_W-1:0] shift_q;   // Address first, then write data in the top bits
    logic                   rw_q;
    logic [`BUS_DATA_W-1:0] wdata_q;
    logic [`BUS_DATA_W-1:0] rdata_q;
    logic                   err_q;
    logic                   on_bus;

    // FSM and bit counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= ST_IDLE;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (cmd.execute) state_q <= ST_WAIT_GNT;
                end
                ST_WAIT_GNT: begin
                    if (grant) begin
                        state_q   <= ST_ADDR;
                        bit_cnt_q <= '0;
                    end
                end
                ST_ADDR: begin
                    bit_cnt_q <= bit_cnt_q + CNT_W'(1);
                    if (bit_cnt_q == ADDR_LAST) state_q <= ST_ACK;
                end
                ST_ACK: begin
                    bit_cnt_q <= '0;
                    if (!ret) state_q <= ST_DONE; // Nobody decoded the address
                    else if (rw_q) state_q <= ST_WDATA;
                    else state_q <= ST_RDATA;
                end
                ST_WDATA, ST_RDATA: begin
                    bit_cnt_q <= bit_cnt_q + CNT_W'(1);
                    if (bit_cnt_q == DATA_LAST) state_q <= ST_DONE;
                end
                default: state_q <= ST_IDLE; // ST_DONE lasts one cycle
            endcase
        end
    end

    // Command latch and serializer
    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (cmd.execute) begin
                    shift_q <= cmd.addr.flat;
                    rw_q    <= cmd.rw;
                    wdata_q <= cmd.wdata;
                    rdata_q <= '0;
                    err_q   <= 1'b0;
                end
            end
            ST_ADDR, ST_WDATA: begin
                shift_q <= {shift_q[`BUS_ADDR_W-2:0], 1'b0};
            end
            ST_ACK: begin
                err_q <= !ret;
                if (ret && rw_q) begin
                    shift_q <= {wdata_q, {(`BUS_ADDR_W - `BUS_DATA_W){1'b0}}};
                end
            end
            ST_RDATA: begin
                rdata_q <= {rdata_q[`BUS_DATA_W-2:0], ret}; // MSB arrives first
            end
            default: ;
        endcase
    end

    assign on_bus = (state_q == ST_ADDR) || (state_q == ST_ACK) ||
                    (state_q == ST_WDATA) || (state_q == ST_RDATA);

    // Request drops in the dvalid cycle
    assign request = on_bus || (state_q == ST_WAIT_GNT);
    assign busy    = (state_q != ST_IDLE);

    always_comb begin
        lines.active = on_bus;
        lines.rw     = on_bus && rw_q;
        lines.sdata  = ((state_q == ST_ADDR) || (state_q == ST_WDATA)) &&
                       shift_q[`BUS_ADDR_W-1];
    end

    always_comb begin
        rsp.dvalid = (state_q == ST_DONE);
        rsp.error  = err_q;
        rsp.rdata  = rdata_q;
    end

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module bus_arbiter (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [`BUS_NUM_MASTERS-1:0] request,
    input  bus_pkg::bus_lines_t         master_lines [`BUS_NUM_MASTERS],
    output logic [`BUS_NUM_MASTERS-1:0] grant,
    output bus_pkg::bus_lines_t         bus,
    output logic                        utilization
);
    import bus_pkg::*;

    logic [`BUS_NUM_MASTERS-1:0] next_grant;

    // Fixed priority, lowest index wins
    always_comb begin
        next_grant = '0;
        for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
            if (request[i] && (next_grant == '0)) begin
                next_grant[i] = 1'b1;
            end
        end
    end

    // Four-phase handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant <= '0;
        end else if (grant == '0) begin
            grant <= next_grant; // New grant only from an idle bus
        end else begin
            grant <= grant & request; // Release one cycle after request drops
        end
    end

    // Granted master drives the slaves
    always_comb begin
        bus = '0;
        for (int i = 0; i < `BUS_NUM_MASTERS; i++) begin
            if (grant[i]) begin
                bus = master_lines[i];
            end
        end
    end

    assign utilization = |grant;

endmodule

`default_nettype wire

//--- hw/memory_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module memory_slave #(
    parameter logic [`BUS_SLV_ID_W-1:0] SLAVE_ID = '0
) (
    input  logic                clk,
    input  logic                arst_n,
    input  bus_pkg::bus_lines_t bus,
    output logic                ret
);
    import bus_pkg::*;

    localparam int CNT_W     = $clog2(`BUS_ADDR_W + `BUS_DATA_W + 1);
    localparam int SW        = `BUS_DATA_W - 1;
    localparam int MEM_WORDS = 1 << `BUS_MEM_ADDR_W;

    // Frame positions counted from the first address bit
    localparam logic [CNT_W-1:0] ACK_CNT       = CNT_W'(`BUS_ADDR_W);
    localparam logic [CNT_W-1:0] DATA_LAST_CNT = CNT_W'(`BUS_ADDR_W + `BUS_DATA_W);

    logic [CNT_W-1:0]          cnt_q;
    logic                      sel_q;       // Addressed in this frame
    bus_addr_u                 addr_q;
    bus_addr_u                 addr_next;
    logic                      id_hit;
    logic [SW-1:0]             rd_shift_q;
    logic [SW-1:0]             wr_shift_q;
    logic [`BUS_MEM_ADDR_W-1:0] mem_idx;
    logic [`BUS_DATA_W-1:0]    mem [MEM_WORDS];

    always_comb begin
        addr_next.flat = {addr_q.flat[`BUS_ADDR_W-2:0], bus.sdata};
    end

    // Checked while the last address bit is on the line
    assign id_hit  = (addr_next.fields.slv_id == SLAVE_ID);
    assign mem_idx = addr_q.fields.offset[`BUS_MEM_ADDR_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
            sel_q <= 1'b0;
            ret   <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ret <= 1'b0;
            if (!bus.active) begin
                cnt_q <= '0;
                sel_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q + CNT_W'(1);
                if ((cnt_q == ACK_CNT - CNT_W'(1)) && id_hit) begin
                    sel_q <= 1'b1;
                    ret   <= 1'b1; // Acknowledge
                end
                if (sel_q && !bus.rw) begin
                    if (cnt_q == ACK_CNT) begin
                        ret <= mem[mem_idx][SW];
                    end else if ((cnt_q > ACK_CNT) && (cnt_q < DATA_LAST_CNT)) begin
                        ret <= rd_shift_q[SW-1];
                    end
                end
                if (sel_q && bus.rw && (cnt_q == DATA_LAST_CNT)) begin
                    mem[mem_idx] <= {wr_shift_q, bus.sdata}; // Last bit still on the line
                end
            end
        end
    end

    // Address and data shifters
    always_ff @(posedge clk) begin
        if (bus.active) begin
            if (cnt_q < ACK_CNT) begin
                addr_q <= addr_next;
            end
            if (cnt_q == ACK_CNT) begin
                rd_shift_q <= mem[mem_idx][SW-1:0];
            end else begin
                rd_shift_q <= {rd_shift_q[SW-2:0], 1'b0};
            end
            if (cnt_q > ACK_CNT) begin
                wr_shift_q <= {wr_shift_q[SW-2:0], bus.sdata};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/serial_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module serial_bus_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  bus_pkg::master_cmd_t        cmd [`BUS_NUM_MASTERS],
    output bus_pkg::master_rsp_t        rsp [`BUS_NUM_MASTERS],
    output logic [`BUS_NUM_MASTERS-1:0] busy,
    output logic [`BUS_NUM_MASTERS-1:0] grant,
    output logic                        utilization
);
    import bus_pkg::*;

    logic [`BUS_NUM_MASTERS-1:0] request;
    bus_lines_t                  master_lines [`BUS_NUM_MASTERS];
    bus_lines_t                  bus;
    logic                        ret_s3;
    logic                        ret_s4;
    logic                        ret;

    for (genvar i = 0; i < `BUS_NUM_MASTERS; i++) begin : g_master
        bus_master u_master (
            .clk     (clk),
            .arst_n  (arst_n),
            .cmd     (cmd[i]),
            .grant   (grant[i]),
            .ret     (ret),
            .request (request[i]),
            .lines   (master_lines[i]),
            .rsp     (rsp[i]),
            .busy    (busy[i])
        );
    end

    bus_arbiter u_arbiter (
        .clk          (clk),
        .arst_n       (arst_n),
        .request      (request),
        .master_lines (master_lines),
        .grant        (grant),
        .bus          (bus),
        .utilization  (utilization)
    );

    memory_slave #(.SLAVE_ID(3'd3)) u_slave3 (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (bus),
        .ret    (ret_s3)
    );

    memory_slave #(.SLAVE_ID(3'd4)) u_slave4 (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (bus),
        .ret    (ret_s4)
    );

    // Only the addressed slave ever drives a 1
    assign ret = ret_s3 | ret_s4;

endmodule

`default_nettype wire

//--- tb/bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module bus_checker (
    input logic                        clk,
    input logic                        arst_n,
    input logic [`BUS_NUM_MASTERS-1:0] request,
    input logic [`BUS_NUM_MASTERS-1:0] grant,
    input logic                        utilization
);

    // Never two owners on the bus
    a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant))
        else $error("More than one grant high: %b", grant);

    a_utilization: assert property (@(posedge clk) disable iff (!arst_n)
        utilization == (|grant))
        else $error("utilization %b does not follow grant %b", utilization, grant);

    for (genvar i = 0; i < `BUS_NUM_MASTERS; i++) begin : g_master
        // Grant only answers a request seen on the previous edge
        a_grant_on_request: assert property (@(posedge clk) disable iff (!arst_n)
            $rose(grant[i]) |-> $past(request[i]))
            else $error("Grant %0d rose without a request", i);

        a_grant_held: assert property (@(posedge clk) disable iff (!arst_n)
            (grant[i] && request[i]) |=> grant[i])
            else $error("Grant %0d dropped while its request was held", i);
    end

endmodule

bind bus_arbiter bus_checker u_bus_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .request     (request),
    .grant       (grant),
    .utilization (utilization)
);

`default_nettype wire

//--- tb/tb_serial_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module tb_serial_bus;
    import bus_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TXN    = 400;  // Upper bound on transactions in one run
    localparam int RAND_TXN   = 150;  // Random commands per master
    localparam int MAX_LAT    = 30;
    localparam int MAX_ISSUE  = 256;
    localparam int MEM_WORDS  = 1 << `BUS_MEM_ADDR_W;

    logic                        clk;
    logic                        arst_n;
    master_cmd_t                 cmd [`BUS_NUM_MASTERS];
    master_rsp_t                 rsp [`BUS_NUM_MASTERS];
    logic [`BUS_NUM_MASTERS-1:0] busy;
    logic [`BUS_NUM_MASTERS-1:0] grant;
    logic                        utilization;

    int seed;
    int cycle      = 0;
    int seq_errors = 0;  // Ordering, timing and reset checks
    int rsp_errors = 0;  // Response checks in the monitor

    // Commands in issue order, consumed by the monitor in completion order
    master_cmd_t issued [`BUS_NUM_MASTERS][MAX_ISSUE];
    int          issued_cnt [`BUS_NUM_MASTERS];
    int          done_cnt [`BUS_NUM_MASTERS];
    int          done_cycle [`BUS_NUM_MASTERS];

    logic [`BUS_DATA_W-1:0] model_s3 [MEM_WORDS];
    logic [`BUS_DATA_W-1:0] model_s4 [MEM_WORDS];

    master_cmd_t rand_cmds [`BUS_NUM_MASTERS][RAND_TXN];
    logic [1:0]  rand_gap [`BUS_NUM_MASTERS][RAND_TXN];

    serial_bus_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd         (cmd),
        .rsp         (rsp),
        .busy        (busy),
        .grant       (grant),
        .utilization (utilization)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        #(NUM_TXN * 60 * CLK_PERIOD);
        $display("Watchdog timeout: the run did not finish in its time limit");
        $display("Sequence errors: %0d, response errors: %0d", seq_errors, rsp_errors);
        $display("Regression failed");
        $finish;
    end

    // Responses against the memory model, one dvalid per cycle at most
    always @(negedge clk) begin
        master_cmd_t            c;
        logic [2:0]             id;
        logic [3:0]             idx;
        logic                   exp_err;
        logic [`BUS_DATA_W-1:0] exp_rdata;
        for (int m = 0; m < `BUS_NUM_MASTERS; m++) begin
            if (rsp[m].dvalid) begin
                // Request drops with dvalid, so the grant is still held here
                if (grant[m] != 1'b1) begin
                    $display("ERROR at %0t: grant[%0d] = %b, expected 1",
                             $time, m, grant[m]);
                    rsp_errors++;
                end
                if (utilization != 1'b1) begin
                    $display("ERROR at %0t: utilization = %b, expected 1",
                             $time, utilization);
                    rsp_errors++;
                end
                if (busy[m] != 1'b1) begin
                    $display("ERROR at %0t: busy[%0d] = %b, expected 1",
                             $time, m, busy[m]);
                    rsp_errors++;
                end
                if (done_cnt[m] >= issued_cnt[m]) begin
                    $display("Master %0d gave dvalid at %0t with no command pending", m, $time);
                    rsp_errors++;
                end else begin
                    c         = issued[m][done_cnt[m]];
                    id        = c.addr.flat[`BUS_ADDR_W-1 -: `BUS_SLV_ID_W];
                    idx       = c.addr.flat[`BUS_MEM_ADDR_W-1:0];
                    exp_err   = (id != 3'd3) && (id != 3'd4);
                    exp_rdata = '0;
                    if (!exp_err && !c.rw) begin
                        exp_rdata = (id == 3'd3) ? model_s3[idx] : model_s4[idx];
                    end
                    if (rsp[m].error != exp_err) begin
                        $display("ERROR at %0t: rsp[%0d].error = %b, expected %b",
                                 $time, m, rsp[m].error, exp_err);
                        rsp_errors++;
                    end
                    if (rsp[m].rdata != exp_rdata) begin
                        $display("ERROR at %0t: rsp[%0d].rdata = %h, expected %h",
                                 $time, m, rsp[m].rdata, exp_rdata);
                        rsp_errors++;
                    end
                    if (!exp_err && c.rw && id == 3'd3) model_s3[idx] = c.wdata;
                    if (!exp_err && c.rw && id == 3'd4) model_s4[idx] = c.wdata;
                    done_cycle[m] = cycle;
                    done_cnt[m]++;
                end
            end
        end
    end

    function automatic master_cmd_t make_cmd(input logic rw, input logic [2:0] id,
                                             input logic [11:0] offset,
                                             input logic [7:0] wdata);
        master_cmd_t c;
        c.execute   = 1'b1;
        c.rw        = rw;
        c.addr.flat = {id, offset};
        c.wdata     = wdata;
        return c;
    endfunction

    task automatic random_cmd(output master_cmd_t c);
        logic [31:0] r;
        logic [2:0]  id;
        r = $random(seed);
        if (r[2:0] < 3'd3) id = 3'd3;
        else if (r[2:0] < 3'd6) id = 3'd4;
        else begin
            id = r[10:8];
            if (id == 3'd3 || id == 3'd4) id = id ^ 3'b001; // Some id with no slave
        end
        c = make_cmd(r[23], id, r[22:11], r[31:24]);
    endtask

    task automatic wait_idle(input int m);
        do begin
            @(negedge clk);
        end while (busy[m] || (done_cnt[m] != issued_cnt[m]));
    endtask

    // One-cycle execute strobe, returns on the edge that samples it
    task automatic pulse_execute(input int m, input master_cmd_t c);
        master_cmd_t off;
        c.execute   = 1'b1;
        off         = c;
        off.execute = 1'b0;
        @(posedge clk);
        cmd[m] <= c;
        @(posedge clk);
        cmd[m] <= off;
    endtask

    task automatic issue(input int m, input master_cmd_t c);
        wait_idle(m);
        issued[m][issued_cnt[m]] = c;
        issued_cnt[m]++;
        pulse_execute(m, c);
    endtask

    task automatic issue_pair(input master_cmd_t c0, input master_cmd_t c1);
        wait_idle(0);
        wait_idle(1);
        issued[0][issued_cnt[0]] = c0;
        issued[1][issued_cnt[1]] = c1;
        issued_cnt[0]++;
        issued_cnt[1]++;
        c0.execute = 1'b1;
        c1.execute = 1'b1;
        @(posedge clk);
        cmd[0] <= c0;
        cmd[1] <= c1;
        c0.execute = 1'b0;
        c1.execute = 1'b0;
        @(posedge clk);
        cmd[0] <= c0;
        cmd[1] <= c1;
    endtask

    task automatic run_random(input int m);
        for (int k = 0; k < RAND_TXN; k++) begin
            repeat (rand_gap[m][k]) @(posedge clk);
            issue(m, rand_cmds[m][k]);
        end
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic check_quiet_outputs();
        repeat (4) begin
            @(negedge clk);
            if (busy != '0) begin
                $display("ERROR at %0t: busy = %b, expected 00", $time, busy);
                seq_errors++;
            end
            if (grant != '0) begin
                $display("ERROR at %0t: grant = %b, expected 00", $time, grant);
                seq_errors++;
            end
            if (utilization) begin
                $display("ERROR at %0t: utilization = 1, expected 0", $time);
                seq_errors++;
            end
            if (rsp[0].dvalid || rsp[1].dvalid) begin
                $display("ERROR at %0t: dvalid = %b%b, expected 00",
                         $time, rsp[1].dvalid, rsp[0].dvalid);
                seq_errors++;
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [2:0]  id;
        int          start;
        int          lat;
        seed   = 20590;
        arst_n = 1'b0;
        cmd[0] = '0;
        cmd[1] = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_s3[i] = '0;
            model_s4[i] = '0;
        end
        release_reset();
        check_quiet_outputs();

        // Every word reads as zero before any write
        for (int i = 0; i < MEM_WORDS; i++) begin
            r = $random(seed);
            issue(0, make_cmd(1'b0, 3'd3, {r[7:0], i[3:0]}, 8'h00));
            issue(1, make_cmd(1'b0, 3'd4, {r[15:8], i[3:0]}, 8'h00));
        end
        wait_idle(0);
        wait_idle(1);

        // Uncontested latency, and a strobe lost while busy
        r = $random(seed);
        issue(0, make_cmd(1'b1, 3'd3, {r[7:0], 4'h5}, r[31:24]));
        @(negedge clk);
        start = cycle;
        pulse_execute(0, make_cmd(1'b0, 3'd4, 12'h001, 8'h00));
        wait_idle(0);
        lat = done_cycle[0] - start + 1;
        if (lat > MAX_LAT) begin
            $display("ERROR at %0t: dvalid latency = %0d cycles, expected at most %0d",
                     $time, lat, MAX_LAT);
            seq_errors++;
        end
        repeat (40) @(negedge clk); // A stray dvalid shows up in the monitor

        // Same-cycle commands, master 0 goes first
        r = $random(seed);
        issue_pair(make_cmd(1'b1, 3'd4, 12'h007, r[7:0]), make_cmd(1'b0, 3'd4, 12'h007, 8'h00));
        wait_idle(0);
        wait_idle(1);
        if (done_cycle[0] >= done_cycle[1]) begin
            $display("Master 1 finished before master 0 after a same-cycle start at %0t", $time);
            seq_errors++;
        end

        // Offsets that differ above the low 4 bits hit the same word
        for (int k = 0; k < 4; k++) begin
            r  = $random(seed);
            id = k[0] ? 3'd4 : 3'd3;
            issue(0, make_cmd(1'b1, id, {r[7:0], r[11:8]}, r[31:24]));
            issue(1, make_cmd(1'b0, id, {r[7:0] ^ 8'h5A, r[11:8]}, 8'h00));
        end

        // No slave at id 6, slave 3 keeps its word
        issue(0, make_cmd(1'b1, 3'd6, 12'h005, 8'hC3));
        issue(1, make_cmd(1'b0, 3'd3, 12'h005, 8'h00));
        wait_idle(0);
        wait_idle(1);

        for (int m = 0; m < `BUS_NUM_MASTERS; m++) begin
            for (int k = 0; k < RAND_TXN; k++) begin
                random_cmd(rand_cmds[m][k]);
                r = $random(seed);
                rand_gap[m][k] = r[1:0];
            end
        end
        fork
            run_random(0);
            run_random(1);
        join
        wait_idle(0);
        wait_idle(1);
        repeat (20) @(negedge clk);

        $display("Transactions: %0d, sequence errors: %0d, response errors: %0d",
                 done_cnt[0] + done_cnt[1], seq_errors, rsp_errors);
        if (seq_errors == 0 && rsp_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hw/bus_pkg.sv
hw/bus_master.sv
hw/bus_arbiter.sv
hw/memory_slave.sv
hw/serial_bus_top.sv
tb/bus_checker.sv
tb/tb_serial_bus.sv

//--- Makefile
SIM := obj_dir/Vtb_serial_bus

.PHONY: all run check clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): list.f $(wildcard include/*.svh hw/*.sv tb/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_serial_bus -f list.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status

check: run
	@if grep -q "Regression failed" sim.log; then echo "check: failure in sim.log"; exit 1; fi
	@echo "check: no failure in sim.log"

clean:
	rm -rf obj_dir sim.log
